// ==== rs_bm_decoder.f ====
rtl/gf256_pkg.sv
rtl/rs_bm_pkg.sv
rtl/syndrome_loader.sv
rtl/bm_iteration_engine.sv
rtl/locator_output.sv
rtl/rs_bm_decoder.sv
tb/rs_bm_properties.sv
tb/rs_bm_checker.sv
tb/tb_rs_bm_decoder.sv

// ==== Makefile ====
TOP := tb_rs_bm_decoder

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rs_bm_decoder.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_rs_bm_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rs_bm_decoder;

    localparam int READY_TIMEOUT = 30;

    logic                 clock;
    logic                 arst_n;
    logic                 start;
    rs_bm_pkg::synd_vec_t synd;
    rs_bm_pkg::locator_t  locator;
    logic                 ready;
    logic [31:0]          lfsr_q;
    int                   timeouts;

    rs_bm_decoder DUT (
        .i_clock   (clock),
        .i_arst_n  (arst_n),
        .i_start   (start),
        .i_synd    (synd),
        .o_locator (locator),
        .o_ready   (ready)
    );

    rs_bm_checker u_checker (
        .i_clock   (clock),
        .i_arst_n  (arst_n),
        .i_start   (start),
        .i_synd    (synd),
        .i_locator (locator),
        .i_ready   (ready)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #50 clock = ~clock;
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    // v * alpha^k as k steps of multiply by x
    function automatic gf256_pkg::gf_t times_alpha_pow(gf256_pkg::gf_t v, int k);
        gf256_pkg::gf_t r;
        r = v;
        for (int i = 0; i < k % 255; i++)
        begin
            r = r[7] ? ({r[6:0], 1'b0} ^ 8'(gf256_pkg::GF_POLY)) : {r[6:0], 1'b0};
        end
        return r;
    endfunction

    task automatic issue_start(input rs_bm_pkg::synd_vec_t s);
        @(posedge clock);
        start <= 1'b1;
        synd  <= s;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // Ready drops after the launch, then returns with the new result
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clock);
        while (ready !== 1'b0 && n < 4)
        begin
            @(negedge clock);
            n++;
        end
        if (ready !== 1'b0)
        begin
            $display("Timeout at %0t: o_ready never dropped after a start", $time);
            timeouts++;
        end
        n = 0;
        while (ready !== 1'b1 && n < READY_TIMEOUT)
        begin
            @(negedge clock);
            n++;
        end
        if (ready !== 1'b1)
        begin
            $display("Timeout at %0t: o_ready never came after a start", $time);
            timeouts++;
        end
    endtask

    task automatic run_injected(input int count);
        int                   pos [3];
        gf256_pkg::gf_t       val [3];
        gf256_pkg::gf_t       poly[4];
        logic [31:0]          r;
        rs_bm_pkg::synd_vec_t s;
        rs_bm_pkg::locator_t  expected;
        s    = '0;
        poly = '{8'h01, 8'h00, 8'h00, 8'h00};
        for (int e = 0; e < count; e++)
        begin
            take_bits(8, r);
            pos[e] = (e == 0) ? int'(r % 255) : (pos[e-1] + 1 + int'(r % 84)) % 255;  // Distinct
            take_bits(8, r);
            val[e] = 8'(r % 255 + 1);
            for (int j = 1; j <= rs_bm_pkg::NUM_SYND; j++)
            begin
                s[j-1] ^= times_alpha_pow(val[e], j * pos[e]);
            end
            for (int k = rs_bm_pkg::T_CORR; k > 0; k--)
            begin
                poly[k] ^= times_alpha_pow(poly[k-1], pos[e]);  // Times (1 + alpha^pos x)
            end
        end
        expected = '0;
        for (int k = 0; k <= rs_bm_pkg::T_CORR; k++)
        begin
            expected.sigma[k] = poly[k];
        end
        expected.degree = rs_bm_pkg::DEG_W'(count);
        issue_start(s);
        wait_ready();
        u_checker.compare_locator(expected);
    endtask

    initial
    begin
        rs_bm_pkg::synd_vec_t s;
        rs_bm_pkg::synd_vec_t s_late;
        rs_bm_pkg::locator_t  zero_loc;
        logic [31:0]          r;
        int                   total;
        arst_n   = 1'b0;
        start    = 1'b0;
        synd     = '0;
        lfsr_q   = 32'hc663_7c11;
        timeouts = 0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        zero_loc          = '0;
        zero_loc.sigma[0] = 8'h01;
        issue_start('0);
        wait_ready();
        u_checker.compare_locator(zero_loc);

        for (int n = 1; n <= rs_bm_pkg::T_CORR; n++)
        begin
            for (int t = 0; t < 3; t++)
            begin
                run_injected(n);
            end
        end

        s = {8'd54, 8'd1, 8'd39, 8'd148, 8'd2, 8'd215};  // S6 down to S1
        issue_start(s);
        wait_ready();

        s = {8'd1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0};  // Only S6 set, length 6
        issue_start(s);
        wait_ready();

        for (int t = 0; t < 8; t++)
        begin
            for (int j = 0; j < rs_bm_pkg::NUM_SYND; j++)
            begin
                take_bits(8, r);
                s[j]      = 8'(r);
                s_late[j] = ~s[j];
            end
            issue_start(s);
            wait_ready();
        end

        // Start held into the launch cycle, the second edge must not count
        @(posedge clock);
        start <= 1'b1;
        synd  <= s;
        @(posedge clock);
        synd  <= s_late;
        @(posedge clock);
        start <= 1'b0;
        wait_ready();

        // Second start lands while the engine is busy and must be dropped
        issue_start(s_late);
        issue_start(s);
        wait_ready();
        repeat (12) @(posedge clock);

        total = u_checker.value_errors + u_checker.timing_errors + timeouts
              + DUT.u_props.fail_count;
        $display("Errors: value %0d, timing %0d, timeout %0d, assertion %0d",
                 u_checker.value_errors, u_checker.timing_errors, timeouts,
                 DUT.u_props.fail_count);
        if (total == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/rs_bm_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_bm_checker (
    input wire                       i_clock,
    input wire                       i_arst_n,
    input wire                       i_start,
    input wire rs_bm_pkg::synd_vec_t i_synd,
    input wire rs_bm_pkg::locator_t  i_locator,
    input wire                       i_ready
);

    localparam int RUN_CYCLES = 8;  // Accepted start to earliest next accepted start

    int   value_errors  = 0;
    int   timing_errors = 0;
    int   cycle         = 0;
    int   last_accept   = -RUN_CYCLES;
    int   due;
    logic ready_prev    = 1'b0;

    rs_bm_pkg::locator_t expected_q[$];
    int                  due_q[$];

    function automatic gf256_pkg::gf_t field_mul(gf256_pkg::gf_t a, gf256_pkg::gf_t b);
        gf256_pkg::gf_t acc;
        gf256_pkg::gf_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc ^= sh;
            end
            sh = sh[7] ? ({sh[6:0], 1'b0} ^ 8'h1d) : {sh[6:0], 1'b0};  // Times x mod 0x11D
        end
        return acc;
    endfunction

    function automatic gf256_pkg::gf_t field_inv(gf256_pkg::gf_t a);
        gf256_pkg::gf_t r;
        r = '0;
        for (int y = 1; y < 256; y++)
        begin
            if (field_mul(a, 8'(y)) == 8'h01)
            begin
                r = 8'(y);
            end
        end
        return r;
    endfunction

    // Textbook Berlekamp-Massey, S1 at index 0
    function automatic rs_bm_pkg::locator_t reference_locator(rs_bm_pkg::synd_vec_t s);
        gf256_pkg::gf_t      c    [rs_bm_pkg::NUM_SYND+1];
        gf256_pkg::gf_t      b_pol[rs_bm_pkg::NUM_SYND+1];
        gf256_pkg::gf_t      c_old[rs_bm_pkg::NUM_SYND+1];
        gf256_pkg::gf_t      d;
        gf256_pkg::gf_t      b;
        gf256_pkg::gf_t      coef;
        int                  len;
        int                  m;
        rs_bm_pkg::locator_t res;
        for (int k = 0; k <= rs_bm_pkg::NUM_SYND; k++)
        begin
            c[k]     = (k == 0) ? 8'h01 : 8'h00;
            b_pol[k] = c[k];
        end
        b   = 8'h01;
        len = 0;
        m   = 1;
        for (int n = 0; n < rs_bm_pkg::NUM_SYND; n++)
        begin
            d = s[n];
            for (int i = 1; i <= len; i++)
            begin
                d ^= field_mul(c[i], s[n - i]);
            end
            if (d == '0)
            begin
                m++;
            end
            else
            begin
                coef  = field_mul(d, field_inv(b));
                c_old = c;
                for (int k = m; k <= rs_bm_pkg::NUM_SYND; k++)
                begin
                    c[k] ^= field_mul(coef, b_pol[k - m]);
                end
                if (2 * len <= n)
                begin
                    len   = n + 1 - len;
                    b_pol = c_old;
                    b     = d;
                    m     = 1;
                end
                else
                begin
                    m++;
                end
            end
        end
        for (int k = 0; k <= rs_bm_pkg::T_CORR; k++)
        begin
            res.sigma[k] = c[k];
        end
        res.degree        = rs_bm_pkg::DEG_W'(len);
        res.uncorrectable = (len > rs_bm_pkg::T_CORR);
        return res;
    endfunction

    task automatic compare_locator(input rs_bm_pkg::locator_t expected);
        if (i_locator !== expected)
        begin
            $display("** Error at %0t: o_locator expected %h, got %h", $time, expected, i_locator);
            value_errors++;
        end
    endtask

    // Sampled mid-cycle, so cycle n sees the values set up for the edge that follows
    always @(negedge i_clock)
    begin
        if (i_arst_n)
        begin
            cycle++;
            if (i_start && cycle >= last_accept + RUN_CYCLES)
            begin
                last_accept = cycle;
                expected_q.push_back(reference_locator(i_synd));
                due_q.push_back(cycle + RUN_CYCLES + 1);
            end
            if (i_ready && !ready_prev)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("o_ready rose at %0t with no accepted start pending", $time);
                    timing_errors++;
                end
                else
                begin
                    due = due_q.pop_front();
                    compare_locator(expected_q.pop_front());
                    if (cycle != due)
                    begin
                        $display("** Error at %0t: o_ready rise expected at cycle %0d, got %0d",
                                 $time, due, cycle);
                        timing_errors++;
                    end
                end
            end
            if (!i_ready && ready_prev && cycle != last_accept + 2)
            begin
                $display("** Error at %0t: o_ready fall expected at cycle %0d, got %0d",
                         $time, last_accept + 2, cycle);
                timing_errors++;
            end
            ready_prev = i_ready;
        end
    end

endmodule

`default_nettype wire

// ==== tb/rs_bm_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_bm_properties (
    input wire i_clock,
    input wire i_arst_n,
    input wire i_ready,
    input wire i_launch,
    input wire i_busy,
    input wire i_done
);

    int fail_count = 0;

    ready_low_after_reset: assert property (@(posedge i_clock) $rose(i_arst_n) |-> !i_ready)
    else
    begin
        $error("o_ready high in the first cycle after reset release");
        fail_count++;
    end

    // Loader must hold off while a run is in flight
    no_launch_while_busy: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_launch |-> !i_busy)
    else
    begin
        $error("w_launch pulsed while w_busy was high");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_done |=> !i_done)
    else
    begin
        $error("w_done stayed high for more than one cycle");
        fail_count++;
    end

endmodule

bind rs_bm_decoder rs_bm_properties u_props (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .i_ready  (o_ready),
    .i_launch (w_launch),
    .i_busy   (w_busy),
    .i_done   (w_done)
);

`default_nettype wire

// ==== rtl/rs_bm_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_bm_decoder (
    input  wire                       i_clock,
    input  wire                       i_arst_n,
    input  wire                       i_start,
    input  wire rs_bm_pkg::synd_vec_t i_synd,
    output rs_bm_pkg::locator_t       o_locator,
    output logic                      o_ready
);

    logic                 w_launch;
    logic                 w_busy;
    logic                 w_done;
    rs_bm_pkg::synd_vec_t w_synd;
    rs_bm_pkg::locator_t  w_result;

    syndrome_loader u_syndrome_loader (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_start  (i_start),
        .i_synd   (i_synd),
        .i_busy   (w_busy),
        .o_synd   (w_synd),
        .o_launch (w_launch)
    );

    bm_iteration_engine u_bm_iteration_engine (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_launch (w_launch),
        .i_synd   (w_synd),
        .o_busy   (w_busy),
        .o_done   (w_done),
        .o_result (w_result)
    );

    locator_output u_locator_output (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_done    (w_done),
        .i_launch  (w_launch),
        .i_result  (w_result),
        .o_locator (o_locator),
        .o_ready   (o_ready)
    );

endmodule

`default_nettype wire

// ==== rtl/locator_output.sv ====
`timescale 1ns/100ps
`default_nettype none

module locator_output (
    input  wire                      i_clock,
    input  wire                      i_arst_n,
    input  wire                      i_done,
    input  wire                      i_launch,
    input  wire rs_bm_pkg::locator_t i_result,
    output rs_bm_pkg::locator_t      o_locator,
    output logic                     o_ready
);

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_locator <= '0;
        end
        else if (i_done)
        begin
            o_locator <= i_result;  // Kept until the next run finishes
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_ready <= 1'b0;
        end
        else if (i_done)
        begin
            o_ready <= 1'b1;
        end
        else if (i_launch)
        begin
            o_ready <= 1'b0;  // New run, old locator no longer current
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bm_iteration_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module bm_iteration_engine (
    input  wire                       i_clock,
    input  wire                       i_arst_n,
    input  wire                       i_launch,
    input  wire rs_bm_pkg::synd_vec_t i_synd,
    output logic                      o_busy,
    output logic                      o_done,
    output rs_bm_pkg::locator_t       o_result
);

    localparam int STEP_W  = $clog2(rs_bm_pkg::NUM_SYND);
    localparam int SHIFT_W = $clog2(rs_bm_pkg::NUM_SYND + 2);

    typedef gf256_pkg::gf_t [rs_bm_pkg::NUM_SYND:0] poly_t;

    poly_t                      conn_q;       // C(x)
    poly_t                      prev_q;       // B(x)
    gf256_pkg::gf_t             disc_prev_q;  // b
    logic [rs_bm_pkg::DEG_W-1:0] len_q;       // L
    logic [SHIFT_W-1:0]          shift_q;     // m
    logic [STEP_W-1:0]           step_q;

    gf256_pkg::gf_t              disc;
    gf256_pkg::gf_t              scale;
    poly_t                       conn_next;
    logic                        len_update;
    logic [rs_bm_pkg::DEG_W-1:0] len_next;

    always_comb
    begin
        disc = '0;
        for (int i = 0; i < rs_bm_pkg::NUM_SYND; i++)
        begin
            if (i <= int'(step_q))
            begin
                disc ^= gf256_pkg::gf_mul(conn_q[i], i_synd[int'(step_q) - i]);
            end
        end

        // C(x) - d/b * x^m * B(x), unchanged when d is zero
        scale = gf256_pkg::gf_mul(disc, gf256_pkg::gf_inv(disc_prev_q));
        conn_next = conn_q;
        for (int k = 1; k <= rs_bm_pkg::NUM_SYND; k++)
        begin
            if (k >= int'(shift_q))
            begin
                conn_next[k] ^= gf256_pkg::gf_mul(scale, prev_q[k - int'(shift_q)]);
            end
        end

        len_update = (disc != '0) && (2 * int'(len_q) <= int'(step_q));
        len_next   = rs_bm_pkg::DEG_W'(step_q) + rs_bm_pkg::DEG_W'(1) - len_q;
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            step_q  <= '0;
            len_q   <= '0;
            shift_q <= '0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_launch)
            begin
                o_busy  <= 1'b1;
                step_q  <= '0;
                len_q   <= '0;
                shift_q <= SHIFT_W'(1);
            end
            else if (o_busy)
            begin
                step_q <= step_q + STEP_W'(1);
                if (len_update)
                begin
                    len_q   <= len_next;
                    shift_q <= SHIFT_W'(1);
                end
                else
                begin
                    shift_q <= shift_q + SHIFT_W'(1);
                end
                if (step_q == STEP_W'(rs_bm_pkg::NUM_SYND - 1))
                begin
                    o_busy <= 1'b0;
                    o_done <= 1'b1;  // Result valid in the done cycle
                end
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_launch)
        begin
            conn_q      <= poly_t'(1);
            prev_q      <= poly_t'(1);
            disc_prev_q <= gf256_pkg::gf_t'(1);
        end
        else if (o_busy)
        begin
            conn_q <= conn_next;
            if (len_update)
            begin
                prev_q      <= conn_q;  // Old C becomes B
                disc_prev_q <= disc;
            end
        end
    end

    // Coefficients above sigma3 are only kept for the degree check
    always_comb
    begin
        o_result.sigma         = conn_q[rs_bm_pkg::T_CORR:0];
        o_result.degree        = len_q;
        o_result.uncorrectable = (len_q > rs_bm_pkg::DEG_W'(rs_bm_pkg::T_CORR));
    end

endmodule

`default_nettype wire

// ==== rtl/syndrome_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module syndrome_loader (
    input  wire                       i_clock,
    input  wire                       i_arst_n,
    input  wire                       i_start,
    input  wire rs_bm_pkg::synd_vec_t i_synd,
    input  wire                       i_busy,
    output rs_bm_pkg::synd_vec_t      o_synd,
    output logic                      o_launch
);

    logic accept;

    // Starts during a run or the launch cycle are dropped
    assign accept = i_start && !i_busy && !o_launch;

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_launch <= 1'b0;
        end
        else
        begin
            o_launch <= accept;  // Single pulse per accepted start
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            o_synd <= i_synd;  // Held for the whole run
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rs_bm_pkg.sv ====
`default_nettype none

package rs_bm_pkg;

    localparam int NUM_SYND = 6;  // 2t syndromes
    localparam int T_CORR   = 3;
    localparam int DEG_W    = 3;

    // S1 sits in element 0
    typedef gf256_pkg::gf_t [NUM_SYND-1:0] synd_vec_t;

    typedef struct packed {
        gf256_pkg::gf_t [T_CORR:0] sigma;   // sigma0 in element 0
        logic [DEG_W-1:0]          degree;  // Final LFSR length
        logic                      uncorrectable;
    } locator_t;

endpackage

`default_nettype wire

// ==== rtl/gf256_pkg.sv ====
`default_nettype none

package gf256_pkg;

    localparam int GF_WIDTH = 8;
    localparam logic [GF_WIDTH:0] GF_POLY = 9'h11D;  // x^8 + x^4 + x^3 + x^2 + 1

    typedef logic [GF_WIDTH-1:0] gf_t;

    // Shift-and-add product, then fold the top bits back with the field polynomial
    function automatic gf_t gf_mul(gf_t a, gf_t b);
        logic [2*GF_WIDTH-2:0] prod;
        prod = '0;
        for (int i = 0; i < GF_WIDTH; i++)
        begin
            if (b[i])
            begin
                prod ^= ({{(GF_WIDTH-1){1'b0}}, a} << i);
            end
        end
        for (int i = 2*GF_WIDTH-2; i >= GF_WIDTH; i--)
        begin
            if (prod[i])
            begin
                prod ^= ({{(GF_WIDTH-2){1'b0}}, GF_POLY} << (i - GF_WIDTH));  // Clear bit i
            end
        end
        return prod[GF_WIDTH-1:0];
    endfunction

    // x^-1 = x^254 since x^255 = 1, zero stays zero
    function automatic gf_t gf_inv(gf_t x);
        gf_t x2;
        gf_t x3;
        gf_t x4;
        gf_t x7;
        gf_t x8;
        gf_t x15;
        gf_t x30;
        gf_t x60;
        gf_t x120;
        gf_t x127;
        x2   = gf_mul(x, x);
        x3   = gf_mul(x, x2);
        x4   = gf_mul(x2, x2);
        x7   = gf_mul(x3, x4);
        x8   = gf_mul(x4, x4);
        x15  = gf_mul(x7, x8);
        x30  = gf_mul(x15, x15);
        x60  = gf_mul(x30, x30);
        x120 = gf_mul(x60, x60);
        x127 = gf_mul(x7, x120);
        return gf_mul(x127, x127);
    endfunction

endpackage

`default_nettype wire
